// File: dv/dma_clock_gen.sv
module dma_clock_gen (
   output logic clk,
   output logic sync_reset
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // period 20
   end

   initial begin
      sync_reset = 1'b1;
      repeat (2) @(posedge clk);
      #2 sync_reset = 1'b0;     // released just after the second edge
   end

endmodule

// File: dv/dma_tb.sv
module dma_tb;
   import dma_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int NUM_ROWS   = 9;

   typedef enum logic [2:0] {
      K_READBACK, K_OAM, K_GDMA, K_STATUS, K_OAM_IN_GDMA, K_GDMA_IN_OAM, K_HBLANK
   } kind_e;

   typedef struct packed {
      kind_e      kind;
      logic [7:0] page;
      logic [7:0] h1, h2, h3, h4, h5;
      int         xfers;        // expected write count
   } row_t;

   logic        I_CLK;
   logic        I_SYNC_RESET;
   cpu_bus_t    cpu;
   logic [7:0]  rd_data;
   mem_req_t    mem;
   logic [7:0]  mem_rd_data;
   logic [7:0]  mem_wr_data;
   logic        halt_cpu;

   row_t        rows [NUM_ROWS];
   logic [15:0] wr_addr_q [$];
   logic [7:0]  wr_data_q [$];
   int          wr_tag_q [$];
   bit          wr_halt_q [$];
   bit          wr_re_q [$];
   int          cycle = 0;
   int          halt_cycles = 0;
   int          last_wr_tag;
   int          errs;
   int          n_pass = 0;
   int          n_fail = 0;
   logic [31:0] rng;
   bit          table_ready = 1'b0;

   dma_clock_gen clk_gen (.clk(I_CLK), .sync_reset(I_SYNC_RESET));

   dma_controller #(.OAM_BYTES(160)) dut0 (
      .I_CLK(I_CLK), .I_SYNC_RESET(I_SYNC_RESET), .cpu(cpu), .rd_data(rd_data), .mem(mem),
      .mem_rd_data(mem_rd_data), .mem_wr_data(mem_wr_data), .halt_cpu(halt_cpu)
   );

   function automatic logic [7:0] model_byte(input logic [15:0] a);
      return a[7:0] ^ a[15:8] ^ 8'h5A;
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [7:0] rand_byte();
      rng = xorshift(rng);
      return rng[7:0];
   endfunction

   assign mem_rd_data = model_byte(mem.rd_addr);   // zero-latency memory

   // write capture tagged with the cycle count before this edge
   always @(posedge I_CLK) begin
      if (mem.we) begin
         wr_addr_q.push_back(mem.wr_addr);
         wr_data_q.push_back(mem_wr_data);
         wr_tag_q.push_back(cycle);
         wr_halt_q.push_back(halt_cpu);
         wr_re_q.push_back(mem.re);
      end
      if (halt_cpu) halt_cycles++;
      cycle++;
   end

   task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", what, got, exp);
         errs++;
      end
   endtask

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
      cpu.addr    = addr;
      cpu.wr_data = data;
      cpu.we      = 1'b1;
      last_wr_tag = cycle;
      @(posedge I_CLK);
      #2 cpu.we = 1'b0;
   endtask

   task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
      cpu.addr = addr;
      cpu.re   = 1'b1;
      #1 data  = rd_data;       // combinational readback
      cpu.re   = 1'b0;
      @(posedge I_CLK);
      #2;
   endtask

   task automatic wait_writes(input int n);
      int k;
      k = 0;
      while (wr_addr_q.size() < n && k < 50) begin
         @(posedge I_CLK);
         #2 k++;
      end
      if (wr_addr_q.size() < n) begin
         $display("transfers never reached %0d bytes", n);
         errs++;
      end
   endtask

   // fixed two-edge start latency before the write strobe is watched
   task automatic wait_done(input int limit);
      int k;
      k = 0;
      repeat (2) @(posedge I_CLK);
      #2;
      while (mem.we && k < limit) begin
         @(posedge I_CLK);
         #2 k++;
      end
      if (mem.we) begin
         $display("DMA still writing after %0d cycles", limit);
         errs++;
      end
   endtask

   task automatic check_copy(input logic [15:0] src, input logic [15:0] dst, input int count,
                             input int first_tag, input bit halted);
      int i;
      check_value("transfer count", wr_addr_q.size(), count);
      for (i = 0; i < wr_addr_q.size() && i < count; i++) begin
         check_value($sformatf("mem.wr_addr[%0d]", i), wr_addr_q[i], dst + i);
         check_value($sformatf("mem_wr_data[%0d]", i), wr_data_q[i], model_byte(src + i));
         check_value($sformatf("write cycle[%0d]", i), wr_tag_q[i], first_tag + i);
         check_value($sformatf("halt_cpu[%0d]", i), wr_halt_q[i], halted);
         check_value($sformatf("mem.re[%0d]", i), wr_re_q[i], 1'b1);
      end
      check_value("halt_cpu cycles", halt_cycles, halted ? count : 0);
   endtask

   task automatic run_row(input int idx, input row_t r);
      logic [15:0] src;
      logic [15:0] dst;
      logic [15:0] reg_addr [5];
      logic [7:0]  reg_val [5];
      logic [7:0]  v;
      int          tag;
      int          i;
      errs = 0;
      wr_addr_q.delete();
      wr_data_q.delete();
      wr_tag_q.delete();
      wr_halt_q.delete();
      wr_re_q.delete();
      halt_cycles = 0;
      src = (16'(r.h1) << 8) | 16'(r.h2 & 8'hF0);
      dst = 16'h8000 + (16'(r.h3 & 8'h1F) << 8) + 16'(r.h4 & 8'hF0);
      reg_addr = '{HDMA1, HDMA2, HDMA3, HDMA4, DMA_REG};
      reg_val  = '{r.h1, r.h2, r.h3, r.h4, r.page};
      case (r.kind)
         K_READBACK: begin
            check_value("mem.re", mem.re, 0);
            check_value("mem.we", mem.we, 0);
            check_value("halt_cpu", halt_cpu, 0);
            cpu_read(HDMA5, v);
            check_value("HDMA5 after reset", v, 8'hFF);
            for (i = 0; i < 5; i++) cpu_write(reg_addr[i], reg_val[i]);
            tag = last_wr_tag;  // DMA_REG goes last and starts the oam copy
            for (i = 0; i < 5; i++) begin
               cpu_read(reg_addr[i], v);
               check_value($sformatf("rd_data @%h", reg_addr[i]), v, reg_val[i]);
            end
            wait_done(r.xfers + 10);
            check_copy({r.page, 8'h00}, {OAM_PAGE, 8'h00}, r.xfers, tag + 2, 1'b0);
         end
         K_OAM, K_GDMA_IN_OAM: begin
            cpu_write(DMA_REG, r.page);
            tag = last_wr_tag;
            if (r.kind == K_GDMA_IN_OAM) begin
               wait_writes(5);
               cpu_write(HDMA5, r.h5);   // refused while oam owns memory
            end
            wait_done(r.xfers + 10);
            check_copy({r.page, 8'h00}, {OAM_PAGE, 8'h00}, r.xfers, tag + 2, 1'b0);
         end
         K_GDMA, K_STATUS, K_OAM_IN_GDMA: begin
            for (i = 0; i < 4; i++) cpu_write(reg_addr[i], reg_val[i]);
            cpu_write(HDMA5, r.h5);
            tag = last_wr_tag;
            if (r.kind == K_STATUS) begin
               wait_writes(BLOCK_BYTES + 1);
               cpu_read(HDMA5, v);
               check_value("HDMA5[7] while busy", v[7], 0);
               if (v[6:0] >= 7'd3) begin
                  $display("[FAIL] HDMA5[6:0] got %h expected below 03", v[6:0]);
                  errs++;
               end
            end
            if (r.kind == K_OAM_IN_GDMA) begin
               wait_writes(5);
               cpu_write(DMA_REG, r.page);
            end
            wait_done(r.xfers + 10);
            check_copy(src, dst, r.xfers, tag + 2, 1'b1);
         end
         default: begin
            cpu_write(HDMA5, r.h5);     // hblank request moves nothing
            repeat (8) @(posedge I_CLK);
            #2 check_copy(16'h0, 16'h0, 0, 0, 1'b0);
         end
      endcase
      cpu_read(HDMA5, v);
      check_value("HDMA5 after test", v, 8'hFF);
      $display("test %0d %s: %s", idx, r.kind.name(), (errs == 0) ? "pass" : "fail");
      if (errs == 0) n_pass++;
      else n_fail++;
   endtask

   task automatic build_table();
      logic [7:0] n;
      rows[0] = '{K_READBACK, rand_byte(), rand_byte(), rand_byte(), rand_byte(), rand_byte(),
                  8'h00, 160};
      rows[1] = '{K_OAM, 8'hC1, 8'h0, 8'h0, 8'h0, 8'h0, 8'h0, 160};
      rows[2] = '{K_OAM, rand_byte(), 8'h0, 8'h0, 8'h0, 8'h0, 8'h0, 160};
      rows[3] = '{K_GDMA, 8'h0, 8'h12, 8'h3F, 8'hE5, 8'h7C, 8'h01, 32};
      n = rand_byte() & 8'h03;
      rows[4] = '{K_GDMA, 8'h0, rand_byte(), rand_byte(), rand_byte(), rand_byte(), n,
                  16 * (n + 1)};
      rows[5] = '{K_STATUS, 8'h0, 8'hC0, 8'h00, 8'h08, 8'h00, 8'h03, 64};
      rows[6] = '{K_OAM_IN_GDMA, 8'h33, 8'h40, 8'h80, 8'h1E, 8'hF0, 8'h02, 48};
      rows[7] = '{K_GDMA_IN_OAM, 8'h7E, 8'h0, 8'h0, 8'h0, 8'h0, 8'h05, 160};
      rows[8] = '{K_HBLANK, 8'h0, 8'h0, 8'h0, 8'h0, 8'h0, 8'h83, 0};
   endtask

   initial begin : watchdog
      int budget;
      int i;
      budget = 0;
      wait (table_ready);
      for (i = 0; i < NUM_ROWS; i++) budget += rows[i].xfers + 50;
      #(budget * CLK_PERIOD);
      $display("watchdog: run did not finish within %0d cycles", budget);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin : main_seq
      int i;
      cpu = '0;
      rng = 32'd31487;
      build_table();
      table_ready = 1'b1;
      wait (I_SYNC_RESET === 1'b0);
      @(posedge I_CLK);
      #2;
      for (i = 0; i < NUM_ROWS; i++) run_row(i, rows[i]);
      $display("tests passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) $display("Simulation PASSED");
      else $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: source/dma_controller.sv
module dma_controller #(
   parameter int OAM_BYTES = 160
) (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  dma_pkg::cpu_bus_t cpu,
   output logic [7:0]        rd_data,
   output dma_pkg::mem_req_t mem,
   input  logic [7:0]        mem_rd_data,
   output logic [7:0]        mem_wr_data,
   output logic              halt_cpu
);
   import dma_pkg::*;

   logic        oam_start;
   logic        gdma_start;
   logic        oam_busy;
   logic        gdma_busy;
   logic        gdma_halt;
   logic [7:0]  oam_src_page;
   logic [15:0] gdma_src;
   logic [15:0] gdma_dst;
   logic [6:0]  gdma_blocks;
   logic [6:0]  gdma_remaining;
   mem_req_t    oam_req;
   mem_req_t    gdma_req;

   dma_regs u_regs (
      .I_CLK          (I_CLK),
      .I_SYNC_RESET   (I_SYNC_RESET),
      .cpu            (cpu),
      .rd_data        (rd_data),
      .oam_busy       (oam_busy),
      .gdma_busy      (gdma_busy),
      .gdma_remaining (gdma_remaining),
      .oam_start      (oam_start),
      .gdma_start     (gdma_start),
      .oam_src_page   (oam_src_page),
      .gdma_src       (gdma_src),
      .gdma_dst       (gdma_dst),
      .gdma_blocks    (gdma_blocks)
   );

   oam_dma_engine #(
      .OAM_BYTES (OAM_BYTES)
   ) u_oam (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .start        (oam_start),
      .src_page     (oam_src_page),
      .busy         (oam_busy),
      .req          (oam_req)
   );

   gdma_engine u_gdma (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .start        (gdma_start),
      .src          (gdma_src),
      .dst          (gdma_dst),
      .blocks       (gdma_blocks),
      .busy         (gdma_busy),
      .halt         (gdma_halt),
      .remaining    (gdma_remaining),
      .req          (gdma_req)
   );

   // oam wins, though the start rule keeps both from running together
   always_comb begin
      if (oam_busy) begin
         mem = oam_req;
      end else if (gdma_busy) begin
         mem = gdma_req;
      end else begin
         mem = '0;
      end
   end

   assign mem_wr_data = mem_rd_data;   // zero-latency memory, byte goes straight across
   assign halt_cpu    = gdma_halt;

endmodule

// File: source/dma_pkg.sv
package dma_pkg;

   // cpu-visible register map
   typedef enum logic [15:0] {
      DMA_REG = 16'hFF46,   // oam source page
      HDMA1   = 16'hFF51,   // gdma source high
      HDMA2   = 16'hFF52,   // gdma source low
      HDMA3   = 16'hFF53,   // gdma destination high
      HDMA4   = 16'hFF54,   // gdma destination low
      HDMA5   = 16'hFF55    // length / start, status on read
   } dma_reg_addr_e;

   typedef enum logic {
      OAM_IDLE = 1'b0,
      OAM_COPY = 1'b1
   } oam_state_e;

   typedef enum logic {
      GDMA_IDLE = 1'b0,
      GDMA_COPY = 1'b1
   } gdma_state_e;

   // register bus from the cpu side
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        we;
      logic        re;
   } cpu_bus_t;

   // one read port and one write port, same cycle
   typedef struct packed {
      logic [15:0] rd_addr;
      logic [15:0] wr_addr;
      logic        re;
      logic        we;
   } mem_req_t;

   localparam logic [7:0] OAM_PAGE       = 8'hFE;    // sprite attribute memory page
   localparam logic [2:0] VRAM_BASE_BITS = 3'b100;   // 8000-9fff window
   localparam int         BLOCK_BYTES    = 16;       // gdma length granule

endpackage

// File: source/dma_regs.sv
module dma_regs (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  dma_pkg::cpu_bus_t cpu,
   output logic [7:0]        rd_data,
   input  logic              oam_busy,
   input  logic              gdma_busy,
   input  logic [6:0]        gdma_remaining,
   output logic              oam_start,
   output logic              gdma_start,
   output logic [7:0]        oam_src_page,
   output logic [15:0]       gdma_src,
   output logic [15:0]       gdma_dst,
   output logic [6:0]        gdma_blocks
);
   import dma_pkg::*;

   logic [7:0] dma_q;
   logic [7:0] hdma1_q;
   logic [7:0] hdma2_q;
   logic [7:0] hdma3_q;
   logic [7:0] hdma4_q;
   logic [6:0] hdma5_q;           // block count only, bit 7 never stored
   logic       engine_claimed;
   logic       wr_dma;
   logic       wr_gdma;

   // a start already in flight also counts as busy
   assign engine_claimed = oam_busy | gdma_busy | oam_start | gdma_start;

   assign wr_dma  = cpu.we && (cpu.addr == DMA_REG);
   assign wr_gdma = cpu.we && (cpu.addr == HDMA5) && !cpu.wr_data[7];

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         dma_q   <= '0;
         hdma1_q <= '0;
         hdma2_q <= '0;
         hdma3_q <= '0;
         hdma4_q <= '0;
         hdma5_q <= '0;
      end else if (cpu.we) begin
         case (cpu.addr)
            DMA_REG: dma_q   <= cpu.wr_data;
            HDMA1:   hdma1_q <= cpu.wr_data;
            HDMA2:   hdma2_q <= cpu.wr_data;
            HDMA3:   hdma3_q <= cpu.wr_data;
            HDMA4:   hdma4_q <= cpu.wr_data;
            HDMA5: begin
               if (!cpu.wr_data[7]) begin   // hblank mode request is dropped
                  hdma5_q <= cpu.wr_data[6:0];
               end
            end
            default: ;
         endcase
      end
   end

   // one-cycle start strobes, refused while the other engine owns memory
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         oam_start  <= 1'b0;
         gdma_start <= 1'b0;
      end else begin
         oam_start  <= wr_dma && !engine_claimed;
         gdma_start <= wr_gdma && !engine_claimed;
      end
   end

   assign oam_src_page = dma_q;
   assign gdma_blocks  = hdma5_q;

   // both addresses are 16-byte aligned
   assign gdma_src = {hdma1_q, hdma2_q[7:4], 4'h0};
   assign gdma_dst = {VRAM_BASE_BITS, hdma3_q[4:0], hdma4_q[7:4], 4'h0};

   always_comb begin
      rd_data = '0;
      if (cpu.re) begin
         case (cpu.addr)
            DMA_REG: rd_data = dma_q;
            HDMA1:   rd_data = hdma1_q;
            HDMA2:   rd_data = hdma2_q;
            HDMA3:   rd_data = hdma3_q;
            HDMA4:   rd_data = hdma4_q;
            HDMA5:   rd_data = {~gdma_busy, gdma_remaining};   // ff when idle
            default: rd_data = '0;
         endcase
      end
   end

endmodule

// File: source/gdma_engine.sv
module gdma_engine (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  logic              start,
   input  logic [15:0]       src,
   input  logic [15:0]       dst,
   input  logic [6:0]        blocks,
   output logic              busy,
   output logic              halt,
   output logic [6:0]        remaining,
   output dma_pkg::mem_req_t req
);
   import dma_pkg::*;

   localparam int BLK_SHIFT = $clog2(BLOCK_BYTES);

   gdma_state_e state_q;
   logic [11:0] cnt_q;        // bytes already moved
   logic [11:0] len_q;        // up to 128 blocks of 16
   logic [15:0] src_q;
   logic [15:0] dst_q;
   logic [11:0] bytes_left;
   logic [11:0] blocks_left;
   logic        last_byte;

   assign busy = (state_q == GDMA_COPY);
   assign halt = busy;        // cpu stays off the bus for every transfer cycle

   assign last_byte   = (cnt_q == len_q - 12'd1);
   assign bytes_left  = len_q - cnt_q;
   assign blocks_left = bytes_left >> BLK_SHIFT;

   // whole blocks left minus one, wraps to 7f on the last block
   assign remaining = busy ? (blocks_left[6:0] - 7'd1) : 7'h7F;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state_q <= GDMA_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            GDMA_IDLE: begin
               if (start) begin
                  state_q <= GDMA_COPY;
                  cnt_q   <= '0;
               end
            end
            GDMA_COPY: begin
               if (last_byte) begin
                  state_q <= GDMA_IDLE;
                  cnt_q   <= '0;
               end else begin
                  cnt_q <= cnt_q + 12'd1;
               end
            end
            default: state_q <= GDMA_IDLE;
         endcase
      end
   end

   // transfer description frozen at start
   always_ff @(posedge I_CLK) begin
      if ((state_q == GDMA_IDLE) && start) begin
         src_q <= src;
         dst_q <= dst;
         len_q <= 12'(BLOCK_BYTES) * (12'(blocks) + 12'd1);
      end
   end

   always_comb begin
      req = '0;
      if (busy) begin
         req.rd_addr = src_q + {4'h0, cnt_q};
         req.wr_addr = dst_q + {4'h0, cnt_q};
         req.re      = 1'b1;
         req.we      = 1'b1;
      end
   end

endmodule

// File: source/oam_dma_engine.sv
module oam_dma_engine #(
   parameter int OAM_BYTES = 160
) (
   input  logic              I_CLK,
   input  logic              I_SYNC_RESET,
   input  logic              start,
   input  logic [7:0]        src_page,
   output logic              busy,
   output dma_pkg::mem_req_t req
);
   import dma_pkg::*;

   localparam logic [7:0] LAST_BYTE = 8'(OAM_BYTES - 1);

   oam_state_e state_q;
   logic [7:0] byte_cnt;
   logic [7:0] page_q;

   assign busy = (state_q == OAM_COPY);

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state_q  <= OAM_IDLE;
         byte_cnt <= '0;
      end else begin
         case (state_q)
            OAM_IDLE: begin
               if (start) begin
                  state_q  <= OAM_COPY;
                  byte_cnt <= '0;
               end
            end
            OAM_COPY: begin
               if (byte_cnt == LAST_BYTE) begin
                  state_q  <= OAM_IDLE;   // last byte goes out this cycle
                  byte_cnt <= '0;
               end else begin
                  byte_cnt <= byte_cnt + 8'd1;
               end
            end
            default: state_q <= OAM_IDLE;
         endcase
      end
   end

   // source page held for the whole copy
   always_ff @(posedge I_CLK) begin
      if ((state_q == OAM_IDLE) && start) begin
         page_q <= src_page;
      end
   end

   // one byte per cycle, same offset on both sides
   always_comb begin
      req = '0;
      if (busy) begin
         req.rd_addr = {page_q, byte_cnt};
         req.wr_addr = {OAM_PAGE, byte_cnt};
         req.re      = 1'b1;
         req.we      = 1'b1;
      end
   end

endmodule

// File: tb.f
source/dma_pkg.sv
source/dma_regs.sv
source/oam_dma_engine.sv
source/gdma_engine.sv
source/dma_controller.sv
dv/dma_clock_gen.sv
dv/dma_tb.sv
